//--- filelist.f
zports_pkg.sv
io_cycle_detect.sv
port_decoder.sv
paging_regs.sv
xt_regs.sv
zports_top.sv
zports_tb_clk.sv
zports_tb.sv

//--- zports_tb.sv
`timescale 1ns/1ns
`default_nettype none

module zports_tb
	import zports_pkg::*;
;

	localparam int CLK_PERIOD      = 10;
	localparam int WATCHDOG_CYCLES = 2000; // generous bound on all tests

	logic zclk, rst_n;
	logic [15:0] a;
	logic [7:0] din, dout, mus_in;
	logic dataout, iorq_n, rd_n, wr_n, porthit, tape_read, dos, rst_rom;
	logic [4:0] keys_in, kj_in;
	logic [7:0] p7ffd, peff7, cvx, vcfg, fp, tp;
	logic pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic [PAGE_W-1:0] pent1m_page;
	logic [BORDER_W-1:0] border;
	logic [SYNC_W-1:0] hs0, hs1, vs0, vs1;
	logic [1:0] fa;
	logic [5:0] tgp0, tgp1;

	// model of the XT file
	logic [5:0] exp_border, exp_tgp0, exp_tgp1;
	logic [7:0] exp_vcfg, exp_fp, exp_tp;
	logic [1:0] exp_fa;
	logic [SYNC_W-1:0] exp_hs0, exp_hs1, exp_vs0, exp_vs1;

	logic [31:0] lcg_state;

	zports_tb_clk zports_tb_clk_i (.zclk(zclk), .rst_n(rst_n));

	zports_top zports_top_i (.*);

	//////////////////////////////////////////////////
	// helpers

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24]; // upper bits are the better ones
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic compare_sync(input string name, input logic [SYNC_W-1:0] exp,
		input logic [SYNC_W-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic compare_page(input string name, input logic [PAGE_W-1:0] exp,
		input logic [PAGE_W-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// every task starts and ends 1 ns after a rising edge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge zclk);
		#1 a = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(posedge zclk);
		#1 iorq_n = 1'b1;
		wr_n = 1'b1;
		repeat (2) @(posedge zclk);
		#1;
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
		output logic hit, output logic en);
		@(posedge zclk);
		#1 a = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		repeat (2) @(posedge zclk);
		#1 data = dout; // mid cycle, away from the edges
		hit = porthit;
		en  = dataout;
		@(posedge zclk);
		#1 iorq_n = 1'b1;
		rd_n = 1'b1;
		repeat (2) @(posedge zclk);
		#1;
	endtask

	task automatic read_and_check(input logic [15:0] addr, input logic exp_hit,
		input logic exp_en, input logic [7:0] exp_data);
		logic [7:0] data;
		logic hit;
		logic en;
		io_read(addr, data, hit, en);
		compare_bit("porthit", exp_hit, hit);
		compare_bit("dataout", exp_en, en);
		if (exp_en)
			compare_byte("dout", exp_data, data);
	endtask

	task automatic check_xt_file();
		compare_byte("border", {2'b00, exp_border}, {2'b00, border});
		compare_byte("vcfg", exp_vcfg, vcfg);
		compare_byte("fp", exp_fp, fp);
		compare_byte("fa", {6'd0, exp_fa}, {6'd0, fa});
		compare_byte("tp", exp_tp, tp);
		compare_byte("tgp0", {2'b00, exp_tgp0}, {2'b00, tgp0});
		compare_byte("tgp1", {2'b00, exp_tgp1}, {2'b00, tgp1});
		compare_sync("hs0", exp_hs0, hs0);
		compare_sync("hs1", exp_hs1, hs1);
		compare_sync("vs0", exp_vs0, vs0);
		compare_sync("vs1", exp_vs1, vs1);
	endtask

	//////////////////////////////////////////////////
	// tests

	task automatic test_reset();
		compare_byte("p7ffd", 8'h10, p7ffd); // rom bit taken from rst_rom
		compare_byte("peff7", 8'h00, peff7);
		compare_byte("vcfg", 8'h00, vcfg);
		compare_bit("pent1m_1m_on", 1'b1, pent1m_1m_on);
	endtask

	task automatic test_decode();
		logic [7:0] r;
		logic [7:0] k;
		r = rand_byte();
		keys_in   = r[4:0];
		tape_read = r[6];
		k = rand_byte();
		kj_in     = k[4:0];
		mus_in    = rand_byte();
		dos = 1'b0;
		read_and_check({8'h00, PORT_FE}, 1'b1, 1'b1, {1'b1, r[6], 1'b0, r[4:0]});
		read_and_check({8'h00, PORT_KJOY}, 1'b1, 1'b1, {3'b000, kj_in});
		read_and_check({8'h00, PORT_KMOUSE}, 1'b1, 1'b1, mus_in);
		read_and_check({8'h00, PORT_SDCFG}, 1'b1, 1'b1, 8'h00);
		read_and_check({8'hEF, PORT_F7}, 1'b1, 1'b1, 8'hFF);
		read_and_check({8'h00, PORT_XT}, 1'b1, 1'b1, 8'hFF);
		read_and_check({8'h00, PORT_CVX}, 1'b1, 1'b1, 8'hFF);
		read_and_check(16'h0057, 1'b1, 1'b1, 8'hFF); // sd data
		read_and_check({8'h7F, PORT_FD}, 1'b1, 1'b0, 8'hFF);
		read_and_check({8'hFF, PORT_FD}, 1'b1, 1'b0, 8'hFF);
		read_and_check(16'h00AB, 1'b0, 1'b0, 8'hFF);
		// shadow mode hides the joystick, sd config and EFF7
		dos = 1'b1;
		read_and_check({8'h00, PORT_KJOY}, 1'b0, 1'b0, 8'hFF);
		read_and_check({8'h00, PORT_SDCFG}, 1'b0, 1'b0, 8'hFF);
		read_and_check({8'hEF, PORT_F7}, 1'b0, 1'b0, 8'hFF);
		read_and_check({8'h00, PORT_KMOUSE}, 1'b1, 1'b1, mus_in);
		read_and_check({8'h00, PORT_FE}, 1'b1, 1'b1, {1'b1, r[6], 1'b0, r[4:0]});
		read_and_check({8'hBF, PORT_FD}, 1'b1, 1'b0, 8'hFF);
		dos = 1'b0;
	endtask

	task automatic test_fe_cvx();
		logic [7:0] d;
		logic [7:0] c;
		d = rand_byte();
		io_write({8'h00, PORT_FE}, d);
		compare_byte("border", {2'b00, d[1], 1'b0, d[2], 1'b0, d[0], 1'b0}, {2'b00, border});
		compare_byte("cvx", {d[4], {7{d[3]}}}, cvx);
		c = rand_byte();
		io_write({8'h00, PORT_CVX}, c);
		compare_byte("cvx", c, cvx);
	endtask

	task automatic test_paging();
		logic [7:0] d;
		logic [7:0] e;
		logic [7:0] f;
		d = rand_byte() & 8'hDF; // lock bit clear
		io_write({8'h7F, PORT_FD}, d);
		compare_byte("p7ffd", d, p7ffd);
		compare_page("pent1m_page", {d[7:5], d[2:0]}, pent1m_page);
		compare_bit("pent1m_rom", d[4], pent1m_rom);
		e = rand_byte() | 8'h04; // 128k mode
		io_write({8'hEF, PORT_F7}, e);
		compare_byte("peff7", {e[7], 1'b0, e[5:4], 3'b000, e[0]}, peff7);
		compare_bit("pent1m_1m_on", 1'b0, pent1m_1m_on);
		compare_bit("pent1m_ram0_0", e[3], pent1m_ram0_0);
		compare_byte("p7ffd", {3'b000, d[4:0]}, p7ffd);
		f = d | 8'h20;
		io_write({8'h7F, PORT_FD}, f);
		io_write({8'h7F, PORT_FD}, ~f); // locked now
		compare_byte("p7ffd", {3'b000, f[4:0]}, p7ffd);
		compare_page("pent1m_page", {f[7:5], f[2:0]}, pent1m_page);
		dos = 1'b1;
		io_write({8'hEF, PORT_F7}, ~e);
		dos = 1'b0;
		compare_byte("peff7", {e[7], 1'b0, e[5:4], 3'b000, e[0]}, peff7);
	endtask

	task automatic test_xt();
		xt_reg_t r;
		logic [7:0] d;
		exp_vcfg = '0;
		exp_hs0  = '0;
		exp_hs1  = '0;
		exp_vs0  = '0;
		exp_vs1  = '0;
		r = r.first();
		repeat (r.num())
		begin
			d = rand_byte();
			io_write({r, PORT_XT}, d);
			case (r)
				XT_BORDER:  exp_border = d[5:0];
				XT_VCONFIG: exp_vcfg = d;
				XT_FPAGE:   exp_fp = d;
				XT_FADDR:   exp_fa = d[1:0];
				XT_TPAGE:   exp_tp = d;
				XT_TGPAGE0: exp_tgp0 = d[5:0];
				XT_TGPAGE1: exp_tgp1 = d[5:0];
				XT_HS0L:    exp_hs0[7:0] = d;
				XT_HS0H:    exp_hs0[8] = d[0];
				XT_VS0L:    exp_vs0[7:0] = d;
				XT_VS0H:    exp_vs0[8] = d[0];
				XT_HS1L:    exp_hs1[7:0] = d;
				XT_HS1H:    exp_hs1[8] = d[0];
				XT_VS1L:    exp_vs1[7:0] = d;
				XT_VS1H:    exp_vs1[8] = d[0];
				default:    ;
			endcase
			r = r.next();
		end
		check_xt_file();
		io_write({8'h05, PORT_XT}, rand_byte()); // unused numbers
		io_write({8'hFF, PORT_XT}, rand_byte());
		check_xt_file();
	endtask

	task automatic test_held_write();
		logic [7:0] d;
		d = rand_byte();
		@(posedge zclk);
		#1 a = {8'h00, PORT_FE};
		din    = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (5) @(posedge zclk);
		#1 din = ~d; // late data must not land
		repeat (5) @(posedge zclk);
		#1 iorq_n = 1'b1;
		wr_n = 1'b1;
		repeat (2) @(posedge zclk);
		#1;
		compare_byte("border", {2'b00, d[1], 1'b0, d[2], 1'b0, d[0], 1'b0}, {2'b00, border});
		compare_byte("cvx", {d[4], {7{d[3]}}}, cvx);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog

	initial
	begin
		lcg_state = 32'h6bd6_8fd8;
		a         = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		keys_in   = '0;
		mus_in    = '0;
		kj_in     = '0;
		tape_read = 1'b0;
		dos       = 1'b0;
		rst_rom   = 1'b1;
		@(posedge rst_n);
		repeat (3) @(posedge zclk); // let the rom sync settle
		#1;
		test_reset();
		test_decode();
		test_fe_cvx();
		test_paging();
		test_xt();
		test_held_write();
		$display("TEST OK");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- zports_tb_clk.sv
`timescale 1ns/1ns
`default_nettype none

module zports_tb_clk
(
	output logic zclk,
	output logic rst_n
);

	initial
	begin
		zclk = 1'b0;
		forever #5 zclk = ~zclk; // 10 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge zclk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- zports_top.sv
`timescale 1ns/1ns
`default_nettype none

module zports_top
	import zports_pkg::*;
(
	input  wire                 zclk,
	input  wire                 rst_n,

	// z80 bus
	input  wire  [15:0]         a,
	input  wire  [7:0]          din,
	output logic [7:0]          dout,
	output logic                dataout,
	input  wire                 iorq_n,
	input  wire                 rd_n,
	input  wire                 wr_n,
	output logic                porthit,

	// peripherals
	input  wire  [4:0]          keys_in,
	input  wire  [7:0]          mus_in,
	input  wire  [4:0]          kj_in,
	input  wire                 tape_read,
	input  wire                 dos,
	input  wire                 rst_rom,

	// paging
	output logic [7:0]          p7ffd,
	output logic [7:0]          peff7,
	output logic                pent1m_rom,
	output logic [PAGE_W-1:0]   pent1m_page,
	output logic                pent1m_1m_on,
	output logic                pent1m_ram0_0,

	// video and sound
	output logic [BORDER_W-1:0] border,
	output logic [7:0]          cvx,
	output logic [7:0]          vcfg,
	output logic [SYNC_W-1:0]   hs0,
	output logic [SYNC_W-1:0]   hs1,
	output logic [SYNC_W-1:0]   vs0,
	output logic [SYNC_W-1:0]   vs1,
	output logic [7:0]          fp,
	output logic [1:0]          fa,
	output logic [7:0]          tp,
	output logic [5:0]          tgp0,
	output logic [5:0]          tgp1
);

	logic      port_wr;
	port_sel_t port_sel;

	//////////////////////////////////////////////////
	// bus side

	io_cycle_detect io_cycle_detect_i (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.port_wr(port_wr),
		.port_rd()
	);

	port_decoder port_decoder_i (
		.a        (a),
		.dos      (dos),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.keys_in  (keys_in),
		.tape_read(tape_read),
		.kj_in    (kj_in),
		.mus_in   (mus_in),
		.port_sel (port_sel),
		.porthit  (porthit),
		.dataout  (dataout),
		.dout     (dout)
	);

	//////////////////////////////////////////////////
	// register blocks

	paging_regs paging_regs_i (
		.zclk         (zclk),
		.rst_n        (rst_n),
		.rst_rom      (rst_rom),
		.port_sel     (port_sel),
		.port_wr      (port_wr),
		.din          (din),
		.p7ffd        (p7ffd),
		.peff7        (peff7),
		.pent1m_rom   (pent1m_rom),
		.pent1m_page  (pent1m_page),
		.pent1m_1m_on (pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0)
	);

	xt_regs xt_regs_i (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.port_sel(port_sel),
		.port_wr (port_wr),
		.xt_addr (a[15:8]), // register number rides on the high byte
		.din     (din),
		.border  (border),
		.cvx     (cvx),
		.vcfg    (vcfg),
		.hs0     (hs0),
		.hs1     (hs1),
		.vs0     (vs0),
		.vs1     (vs1),
		.fp      (fp),
		.fa      (fa),
		.tp      (tp),
		.tgp0    (tgp0),
		.tgp1    (tgp1)
	);

endmodule

`default_nettype wire

//--- xt_regs.sv
`timescale 1ns/1ns
`default_nettype none

module xt_regs
	import zports_pkg::*;
(
	input  wire                 zclk,
	input  wire                 rst_n,
	input  wire  port_sel_t     port_sel,
	input  wire                 port_wr,
	input  wire  [7:0]          xt_addr,
	input  wire  [7:0]          din,
	output logic [BORDER_W-1:0] border,
	output logic [7:0]          cvx,
	output logic [7:0]          vcfg,
	output logic [SYNC_W-1:0]   hs0,
	output logic [SYNC_W-1:0]   hs1,
	output logic [SYNC_W-1:0]   vs0,
	output logic [SYNC_W-1:0]   vs1,
	output logic [7:0]          fp,
	output logic [1:0]          fa,
	output logic [7:0]          tp,
	output logic [5:0]          tgp0,
	output logic [5:0]          tgp1
);

	logic fe_wr;
	logic cvx_wr;
	logic xt_wr;

	assign fe_wr  = port_wr && (port_sel == PS_FE);
	assign cvx_wr = port_wr && (port_sel == PS_CVX);
	assign xt_wr  = port_wr && (port_sel == PS_XT);

	//////////////////////////////////////////////////
	// FE, covox and the XT file

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			cvx    <= '0;
			vcfg   <= '0;
			hs0    <= '0;
			hs1    <= '0;
			vs0    <= '0;
			vs1    <= '0;
			fp     <= '0;
			fa     <= '0;
			tp     <= '0;
			tgp0   <= '0;
			tgp1   <= '0;
		end
		else if (fe_wr)
		begin
			border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0}; // grb, spread for the palette
			cvx    <= {din[4], {7{din[3]}}}; // beeper and tape out into the dac
		end
		else if (cvx_wr)
			cvx <= din;
		else if (xt_wr)
		begin
			case (xt_reg_t'(xt_addr))
				XT_BORDER:  border     <= din[BORDER_W-1:0];
				XT_VCONFIG: vcfg       <= din;
				XT_FPAGE:   fp         <= din;
				XT_FADDR:   fa         <= din[1:0];
				XT_TPAGE:   tp         <= din;
				XT_TGPAGE0: tgp0       <= din[5:0];
				XT_TGPAGE1: tgp1       <= din[5:0];
				XT_HS0L:    hs0[7:0]   <= din;
				XT_HS0H:    hs0[8]     <= din[0]; // high halves hold one bit
				XT_VS0L:    vs0[7:0]   <= din;
				XT_VS0H:    vs0[8]     <= din[0];
				XT_HS1L:    hs1[7:0]   <= din;
				XT_HS1H:    hs1[8]     <= din[0];
				XT_VS1L:    vs1[7:0]   <= din;
				XT_VS1H:    vs1[8]     <= din[0];
				default:    ; // unused numbers ignored
			endcase
		end
	end

	// registers move only on a write strobe
	a_no_spurious: assert property (@(posedge zclk) disable iff (!rst_n)
		!port_wr |=> $stable({border, cvx, vcfg, hs0, hs1, vs0, vs1, fp, fa, tp, tgp0, tgp1}));

endmodule

`default_nettype wire

//--- paging_regs.sv
`timescale 1ns/1ns
`default_nettype none

module paging_regs
	import zports_pkg::*;
(
	input  wire               zclk,
	input  wire               rst_n,
	input  wire               rst_rom,
	input  wire  port_sel_t   port_sel,
	input  wire               port_wr,
	input  wire  [7:0]        din,
	output logic [7:0]        p7ffd,
	output logic [7:0]        peff7,
	output logic              pent1m_rom,
	output logic [PAGE_W-1:0] pent1m_page,
	output logic              pent1m_1m_on,
	output logic              pent1m_ram0_0
);

	logic [7:0] p7ffd_r;
	logic [7:0] peff7_r;
	logic       rom_r;      // rom bit as seen by the memory map
	logic       rst_sync1;
	logic       rst_sync2;  // high during reset and two cycles after
	logic       block1m;    // eff7 bit 2
	logic       block7ffd;
	logic       wr_7ffd;

	assign block1m   = peff7_r[2];
	assign block7ffd = p7ffd_r[5] & block1m; // 48k lock, only in 128k mode
	assign wr_7ffd   = port_wr && (port_sel == PS_7FFD) && !block7ffd;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r <= 8'h00;
			peff7_r <= 8'h00;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_r <= din;
			if (port_wr && (port_sel == PS_EFF7))
				peff7_r <= din;
		end
	end

	//////////////////////////////////////////////////
	// rom selection at reset

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_sync1 <= 1'b1;
			rst_sync2 <= 1'b1;
		end
		else
		begin
			rst_sync1 <= 1'b0;
			rst_sync2 <= rst_sync1;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst_sync2)
			rom_r <= rst_rom;
		else if (wr_7ffd)
			rom_r <= din[4];
	end

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_r[7:5]), rom_r, p7ffd_r[3:0]};
	assign peff7 = block1m ? {peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]} : peff7_r;

	assign pent1m_page   = {p7ffd_r[7:5], p7ffd_r[2:0]};
	assign pent1m_rom    = p7ffd_r[4];
	assign pent1m_1m_on  = ~peff7_r[2];
	assign pent1m_ram0_0 = peff7_r[3];

	a_7ffd_locked: assert property (@(posedge zclk) disable iff (!rst_n)
		(port_wr && (port_sel == PS_7FFD) && block7ffd) |=> $stable({p7ffd_r, rom_r}));

endmodule

`default_nettype wire

//--- port_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module port_decoder
	import zports_pkg::*;
(
	input  wire  [15:0] a,
	input  wire         dos,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire  [4:0]  keys_in,
	input  wire         tape_read,
	input  wire  [4:0]  kj_in,
	input  wire  [7:0]  mus_in,
	output port_sel_t   port_sel,
	output logic        porthit,
	output logic        dataout,
	output logic [7:0]  dout
);

	localparam logic [7:0] PORT_SDDAT = 8'h57; // sd data, hit only

	logic [7:0] loa;
	logic       shadow; // dos rom paged in

	assign loa    = a[7:0];
	assign shadow = dos;

	//////////////////////////////////////////////////
	// address decode

	always_comb
	begin
		port_sel = PS_NONE;
		case (loa)
			PORT_FE:
				port_sel = PS_FE;
			PORT_FD:
				port_sel = a[15] ? PS_OTHER : PS_7FFD; // a15 high is the sound chip
			PORT_F7:
			begin
				if (!shadow)
					port_sel = a[12] ? PS_OTHER : PS_EFF7;
			end
			PORT_XT:
				port_sel = PS_XT;
			PORT_CVX:
				port_sel = PS_CVX;
			PORT_KJOY:
			begin
				if (!shadow) // fdc command port in dos
					port_sel = PS_KJOY;
			end
			PORT_KMOUSE:
				port_sel = PS_KMOUSE;
			PORT_SDCFG:
			begin
				if (!shadow)
					port_sel = PS_SDCFG;
			end
			PORT_SDDAT:
				port_sel = PS_OTHER;
			default:
				port_sel = PS_NONE;
		endcase
	end

	assign porthit = (port_sel != PS_NONE);

	// xxFD reads belong to the sound chip, never answered here
	assign dataout = porthit & ~iorq_n & ~rd_n & (loa != PORT_FD);

	//////////////////////////////////////////////////
	// read data

	always_comb
	begin
		case (port_sel)
			PS_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			PS_KJOY:
				dout = {3'b000, kj_in};
			PS_KMOUSE:
				dout = mus_in;
			PS_SDCFG:
				dout = 8'h00; // card present, not write protected
			default:
				dout = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- io_cycle_detect.sv
`timescale 1ns/1ns
`default_nettype none

module io_cycle_detect
(
	input  wire  zclk,
	input  wire  rst_n,
	input  wire  iorq_n,
	input  wire  rd_n,
	input  wire  wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr_act; // write cycle in progress
	logic iord_act; // read cycle in progress
	logic iowr_reg; // level seen at the previous edge
	logic iord_reg;

	assign iowr_act = ~(iorq_n | wr_n);
	assign iord_act = ~(iorq_n | rd_n);

	// one strobe at the start of each cycle, however long the cpu holds it
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= iowr_act;
			iord_reg <= iord_act;
			port_wr  <= iowr_act & ~iowr_reg; // new write only
			port_rd  <= iord_act & ~iord_reg;
		end
	end

	// a bus cycle is either read or write
	a_rd_wr_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

`default_nettype wire

//--- zports_pkg.sv
`default_nettype none

package zports_pkg;

	//////////////////////////////////////////////////
	// low address byte of each decoded port

	localparam logic [7:0] PORT_FE     = 8'hFE; // border, beeper, keys, tape
	localparam logic [7:0] PORT_FD     = 8'hFD; // 7FFD paging, FFFD/BFFD sound chip
	localparam logic [7:0] PORT_F7     = 8'hF7; // EFF7 extended paging
	localparam logic [7:0] PORT_XT     = 8'h6F; // XT register file, number in a[15:8]
	localparam logic [7:0] PORT_CVX    = 8'hFB; // covox dac
	localparam logic [7:0] PORT_KJOY   = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam logic [7:0] PORT_SDCFG  = 8'h77; // sd card config

	//////////////////////////////////////////////////
	// widths fixed by the memory map

	localparam int SYNC_W   = 9;
	localparam int BORDER_W = 6;
	localparam int PAGE_W   = 6;

	// port picked out by the current address
	typedef enum logic [3:0]
	{
		PS_NONE,
		PS_FE,
		PS_7FFD,
		PS_EFF7,
		PS_XT,
		PS_CVX,
		PS_KJOY,
		PS_KMOUSE,
		PS_SDCFG,
		PS_OTHER // hit, but nothing kept here
	} port_sel_t;

	//////////////////////////////////////////////////
	// XT register numbers

	typedef enum logic [7:0]
	{
		XT_BORDER  = 8'h00,
		XT_VCONFIG = 8'h08,
		XT_FPAGE   = 8'h09,
		XT_FADDR   = 8'h0A,
		XT_TPAGE   = 8'h0B,
		XT_TGPAGE0 = 8'h0C,
		XT_TGPAGE1 = 8'h0D,
		XT_HS0L    = 8'h10,
		XT_HS0H    = 8'h11,
		XT_VS0L    = 8'h12,
		XT_VS0H    = 8'h13,
		XT_HS1L    = 8'h14,
		XT_HS1H    = 8'h15,
		XT_VS1L    = 8'h16,
		XT_VS1H    = 8'h17
	} xt_reg_t;

endpackage

`default_nettype wire
